// ==== debug_uart_top.f ====
hdl/uart_pkg.sv
hdl/debug_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/debug_dumper.sv
hdl/debug_uart_top.sv
sim/debug_uart_props.sv
sim/debug_uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the debug UART testbench with Verilator.
# Run from the project root.

LOG=sim.log
BIN=debug_uart_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module debug_uart_tb \
    -f debug_uart_top.f \
    -o "$BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "run_sim: Verilator build failed with status $build_status"
    exit 1
fi

# keep running past the first assertion so the testbench reports it
./obj_dir/"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "run_sim: FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "run_sim: simulator exited with status $run_status"
    exit 1
fi
echo "run_sim: PASS"
exit 0

// ==== sim/debug_uart_tb.sv ====
module debug_uart_tb;

    localparam int CLK_PERIOD = 8;
    localparam int DUMPS = 4;
    localparam int GOOD_FRAMES = 8;
    localparam int FRAMES = GOOD_FRAMES + 1;
    localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::TICKS_PER_BIT;
    localparam int WATCHDOG_CYCLES =
        (DUMPS * (debug_pkg::DUMP_INTERVAL + 1) + FRAMES * FRAME_CYCLES) * 2;

    logic                             clk_in = 1'b0;
    logic                             reset;
    logic [debug_pkg::WORD_WIDTH-1:0] i_data;
    logic                             i_rx;
    logic                             o_tx;
    logic                             o_dump_busy;
    logic [7:0]                       o_cmd_data;
    logic                             o_cmd_valid;
    logic                             o_cmd_busy;

    int seed;

    debug_uart_top dut_i (
        .clk_in      (clk_in),
        .reset       (reset),
        .i_data      (i_data),
        .i_rx        (i_rx),
        .o_tx        (o_tx),
        .o_dump_busy (o_dump_busy),
        .o_cmd_data  (o_cmd_data),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd_busy  (o_cmd_busy)
    );

    bind debug_uart_top debug_uart_props props_i (
        .clk_in      (clk_in),
        .reset       (reset),
        .i_data      (i_data),
        .i_rx        (i_rx),
        .i_tx        (o_tx),
        .i_dump_busy (o_dump_busy),
        .i_cmd_data  (o_cmd_data),
        .i_cmd_valid (o_cmd_valid),
        .i_cmd_busy  (o_cmd_busy)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // hold the line for whole bit times, changes land just after an edge
    task automatic hold_line(input logic level, input int bits);
        i_rx = level;
        repeat (bits * uart_pkg::TICKS_PER_BIT) @(posedge clk_in);
        #1;
    endtask

    task automatic send_frame(input logic [7:0] value, input logic stop_level);
        int bit_idx;
        hold_line(1'b0, 1);
        for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
            hold_line(value[bit_idx], 1);
        end
        hold_line(stop_level, 1);
        // idle gap lets the receiver re-arm after a bad stop bit
        hold_line(1'b1, 2);
    endtask

    task automatic send_commands();
        int n;
        logic [7:0] value;
        // start inside the first dump so both directions overlap
        @(posedge o_dump_busy);
        @(posedge clk_in);
        #1;
        for (n = 0; n < GOOD_FRAMES; n++) begin
            value = 8'($random(seed));
            send_frame(value, 1'b1);
        end
        value = 8'($random(seed));
        send_frame(value, 1'b0);
    endtask

    task automatic follow_dumps(input int count);
        int n;
        for (n = 0; n < count; n++) begin
            @(posedge o_dump_busy);
            @(negedge o_dump_busy);
            @(posedge clk_in);
            #1;
            i_data = $random(seed);
        end
    endtask

    // stop at the first failed assertion
    always @(posedge clk_in) begin
        if (dut_i.props_i.fail_cnt != 0) begin
            $display("Verification failed");
            $fatal(1, "an assertion in the property checker failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Verification failed");
        $fatal(1, "watchdog expired before all dumps and frames completed");
    end

    initial begin
        seed = 32'h4650_d05a;
        reset = 1'b1;
        i_rx = 1'b1;
        i_data = $random(seed);
        repeat (3) @(posedge clk_in);
        #1;
        reset = 1'b0;

        fork
            follow_dumps(DUMPS);
            send_commands();
        join

        // let the last assertions see their cycle
        repeat (4) @(posedge clk_in);
        if (dut_i.props_i.fail_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end
        else begin
            $display("Verification failed");
            $fatal(1, "assertion failures found at the end of the run");
        end
    end

endmodule

// ==== sim/debug_uart_props.sv ====
// samples one 8N1 frame from a serial line at the middle of each bit
module frame_sampler (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       i_line,
    output logic       o_start,
    output logic       o_done,
    output logic [7:0] o_data,
    output logic       o_stop
);

    logic line_prev;
    logic active;
    int   cnt;

    assign o_start = !active && line_prev && !i_line;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            line_prev <= 1'b1;
            active <= 1'b0;
            cnt <= 0;
            o_done <= 1'b0;
            o_data <= '0;
            o_stop <= 1'b1;
        end
        else begin
            line_prev <= i_line;
            o_done <= 1'b0;
            if (o_start) begin
                active <= 1'b1;
                cnt <= 1;
            end
            else if (active) begin
                cnt <= cnt + 1;
                if (cnt % uart_pkg::TICKS_PER_BIT == uart_pkg::HALF_BIT) begin
                    if (cnt / uart_pkg::TICKS_PER_BIT == uart_pkg::FRAME_BITS - 1) begin
                        o_stop <= i_line;
                        o_done <= 1'b1;
                        active <= 1'b0;
                    end
                    else if (cnt / uart_pkg::TICKS_PER_BIT >= 1) begin
                        // lsb arrives first
                        o_data <= {i_line, o_data[7:1]};
                    end
                end
            end
        end
    end

endmodule

module debug_uart_props (
    input logic                             clk_in,
    input logic                             reset,
    input logic [debug_pkg::WORD_WIDTH-1:0] i_data,
    input logic                             i_rx,
    input logic                             i_tx,
    input logic                             i_dump_busy,
    input logic [7:0]                       i_cmd_data,
    input logic                             i_cmd_valid,
    input logic                             i_cmd_busy
);

    int fail_cnt = 0;

    logic       tx_done;
    logic       tx_stop;
    logic [7:0] tx_byte;
    logic       rx_start;
    logic       rx_done;
    logic       rx_stop;
    logic [7:0] rx_byte;

    logic busy_prev;
    logic rise_seen;
    logic dump_rise;
    int   rise_gap;
    int   tx_idx;

    logic [debug_pkg::WORD_WIDTH-1:0] data_q;
    logic [debug_pkg::WORD_WIDTH-1:0] word_copy;
    logic [7:0] exp_tx_byte;

    logic       rx_pending;
    logic       bad_pending;
    int         rx_wait;
    logic [7:0] rx_exp;

    frame_sampler tx_sampler_i (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_line  (i_tx),
        .o_start (),
        .o_done  (tx_done),
        .o_data  (tx_byte),
        .o_stop  (tx_stop)
    );

    frame_sampler rx_sampler_i (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_line  (i_rx),
        .o_start (rx_start),
        .o_done  (rx_done),
        .o_data  (rx_byte),
        .o_stop  (rx_stop)
    );

    assign dump_rise = i_dump_busy && !busy_prev;

    // msb first, then the newline byte
    always_comb begin
        if (tx_idx < debug_pkg::WORD_BYTES) begin
            exp_tx_byte = word_copy[debug_pkg::WORD_WIDTH - 1 - 8 * tx_idx -: 8];
        end
        else begin
            exp_tx_byte = debug_pkg::TERMINATOR;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            busy_prev <= 1'b0;
            rise_seen <= 1'b0;
            rise_gap <= 0;
            tx_idx <= 0;
            data_q <= '0;
            word_copy <= '0;
            rx_pending <= 1'b0;
            bad_pending <= 1'b0;
            rx_wait <= 0;
            rx_exp <= '0;
        end
        else begin
            busy_prev <= i_dump_busy;
            // dut captures the word one edge before busy is seen
            data_q <= i_data;
            rise_gap <= dump_rise ? 1 : rise_gap + 1;
            if (dump_rise) begin
                rise_seen <= 1'b1;
                word_copy <= data_q;
                tx_idx <= 0;
            end
            else if (tx_done) begin
                tx_idx <= tx_idx + 1;
            end
            if (rx_done && rx_stop) begin
                rx_pending <= 1'b1;
                rx_exp <= rx_byte;
                rx_wait <= 0;
            end
            else if (i_cmd_valid) begin
                rx_pending <= 1'b0;
            end
            else begin
                rx_wait <= rx_wait + 1;
            end
            if (rx_done && !rx_stop) begin
                bad_pending <= 1'b1;
            end
            else if (rx_start) begin
                bad_pending <= 1'b0;
            end
        end
    end

    a_idle_start: assert property (@(posedge clk_in) disable iff (reset)
        !rise_seen |-> i_tx && !i_cmd_valid && !i_cmd_busy)
        else begin
            fail_cnt++;
            $error("** Error o_tx o_cmd_valid o_cmd_busy: got %h %h %h, expected 1 0 0",
                i_tx, i_cmd_valid, i_cmd_busy);
        end

    a_idle_line: assert property (@(posedge clk_in) disable iff (reset)
        !i_dump_busy |-> i_tx)
        else begin
            fail_cnt++;
            $error("** Error o_tx: got %h, expected 1 while no dump runs", i_tx);
        end

    // the first rise counts from reset release, when the counter starts at zero
    a_period: assert property (@(posedge clk_in) disable iff (reset)
        dump_rise |-> rise_gap == debug_pkg::DUMP_INTERVAL + 1)
        else begin
            fail_cnt++;
            $error("** Error o_dump_busy period: got %h, expected %h",
                rise_gap, debug_pkg::DUMP_INTERVAL + 1);
        end

    a_tx_stop: assert property (@(posedge clk_in) disable iff (reset)
        tx_done |-> tx_stop)
        else begin
            fail_cnt++;
            $error("** Error o_tx stop bit: got %h, expected 1", tx_stop);
        end

    a_tx_byte: assert property (@(posedge clk_in) disable iff (reset)
        tx_done |-> tx_byte == exp_tx_byte)
        else begin
            fail_cnt++;
            $error("** Error o_tx byte %0d: got %h, expected %h", tx_idx, tx_byte, exp_tx_byte);
        end

    a_dump_end: assert property (@(posedge clk_in) disable iff (reset)
        $fell(i_dump_busy) |-> tx_idx == debug_pkg::WORD_BYTES + 1)
        else begin
            fail_cnt++;
            $error("** Error o_dump_busy fell after %h frames, expected %h",
                tx_idx, debug_pkg::WORD_BYTES + 1);
        end

    a_cmd_data: assert property (@(posedge clk_in) disable iff (reset)
        i_cmd_valid |-> rx_pending && i_cmd_data == rx_exp)
        else begin
            fail_cnt++;
            $error("** Error o_cmd_data: got %h, expected %h", i_cmd_data, rx_exp);
        end

    a_cmd_late: assert property (@(posedge clk_in) disable iff (reset)
        rx_pending |-> rx_wait < uart_pkg::TICKS_PER_BIT)
        else begin
            fail_cnt++;
            $error("o_cmd_valid did not follow a good frame within one bit time");
        end

    a_cmd_busy: assert property (@(posedge clk_in) disable iff (reset)
        i_cmd_valid |=> !i_cmd_busy)
        else begin
            fail_cnt++;
            $error("** Error o_cmd_busy: got %h after the valid pulse, expected 0", i_cmd_busy);
        end

    a_frame_err: assert property (@(posedge clk_in) disable iff (reset)
        bad_pending |-> !i_cmd_valid)
        else begin
            fail_cnt++;
            $error("o_cmd_valid pulsed for a frame with a low stop bit");
        end

endmodule

// ==== hdl/debug_uart_top.sv ====
module debug_uart_top (
    input  logic                             clk_in,
    input  logic                             reset,
    input  logic [debug_pkg::WORD_WIDTH-1:0] i_data,
    input  logic                             i_rx,
    output logic                             o_tx,
    output logic                             o_dump_busy,
    output logic [7:0]                       o_cmd_data,
    output logic                             o_cmd_valid,
    output logic                             o_cmd_busy
);

    // dumper to transmitter link
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;

    debug_dumper dumper_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_data     (i_data),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte),
        .o_busy     (o_dump_busy)
    );

    uart_tx tx_i (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_start (tx_start),
        .i_byte  (tx_byte),
        .o_busy  (tx_busy),
        .o_tx    (o_tx)
    );

    // command bytes go straight out for the host design to decode
    uart_rx rx_i (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_rx    (i_rx),
        .o_data  (o_cmd_data),
        .o_valid (o_cmd_valid),
        .o_busy  (o_cmd_busy)
    );

endmodule

// ==== hdl/debug_dumper.sv ====
module debug_dumper (
    input  logic                             clk_in,
    input  logic                             reset,
    input  logic [debug_pkg::WORD_WIDTH-1:0] i_data,
    input  logic                             i_tx_busy,
    output logic                             o_tx_start,
    output logic [7:0]                       o_tx_byte,
    output logic                             o_busy
);

    logic [debug_pkg::CNT_WIDTH-1:0] interval_cnt;
    logic strobe;

    // snapshot of the status word for the running dump
    logic [debug_pkg::WORD_WIDTH-1:0] word_q;

    // data bytes still to send, zero selects the terminator
    logic [debug_pkg::IDX_WIDTH-1:0] byte_idx;

    logic [debug_pkg::SEQ_WIDTH-1:0] state;

    // transmitter has gone busy for the current byte
    logic tx_seen;

    logic [7:0] next_byte;

    assign strobe = (interval_cnt == debug_pkg::CNT_LAST);

    // free-running, wraps on the terminal value
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            interval_cnt <= '0;
        end
        else if (strobe) begin
            interval_cnt <= '0;
        end
        else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    // msb first, so the highest remaining index is the top byte
    always_comb begin
        if (byte_idx == '0) begin
            next_byte = debug_pkg::TERMINATOR;
        end
        else begin
            next_byte = word_q[8 * (byte_idx - 1) +: 8];
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= debug_pkg::SEQ_IDLE;
            word_q <= '0;
            byte_idx <= '0;
            o_tx_byte <= '0;
            o_tx_start <= 1'b0;
            o_busy <= 1'b0;
            tx_seen <= 1'b0;
        end
        else begin
            case (state)
                debug_pkg::SEQ_IDLE: begin
                    // strobes during a dump never get here
                    if (strobe) begin
                        word_q <= i_data;
                        byte_idx <= debug_pkg::IDX_FIRST;
                        o_busy <= 1'b1;
                        state <= debug_pkg::SEQ_LOAD;
                    end
                end
                debug_pkg::SEQ_LOAD: begin
                    o_tx_byte <= next_byte;
                    state <= debug_pkg::SEQ_SEND;
                end
                debug_pkg::SEQ_SEND: begin
                    if (!i_tx_busy) begin
                        o_tx_start <= 1'b1;
                        tx_seen <= 1'b0;
                        state <= debug_pkg::SEQ_WAIT;
                    end
                end
                debug_pkg::SEQ_WAIT: begin
                    o_tx_start <= 1'b0;
                    // busy lags the strobe by a cycle, so wait for high then low
                    if (i_tx_busy) begin
                        tx_seen <= 1'b1;
                    end
                    else if (tx_seen) begin
                        if (byte_idx == '0) begin
                            o_busy <= 1'b0;
                            state <= debug_pkg::SEQ_IDLE;
                        end
                        else begin
                            byte_idx <= byte_idx - 1'b1;
                            state <= debug_pkg::SEQ_LOAD;
                        end
                    end
                end
                default: begin
                    state <= debug_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
module uart_rx (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       i_rx,
    output logic [7:0] o_data,
    output logic       o_valid,
    output logic       o_busy
);

    // two-flop synchronizer plus one delay for edge detect
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    // set after a bad stop bit until the line is high again
    logic wait_high;

    logic [uart_pkg::TICK_WIDTH-1:0] tick_cnt;
    logic [uart_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;
    logic [7:0] shift_q;

    logic start_edge;
    logic sample;
    logic bit_end;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rx_meta <= uart_pkg::LINE_IDLE;
            rx_sync <= uart_pkg::LINE_IDLE;
            rx_prev <= uart_pkg::LINE_IDLE;
        end
        else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = (rx_prev == uart_pkg::LINE_IDLE) && (rx_sync != uart_pkg::LINE_IDLE);
    assign sample = o_busy && (tick_cnt == uart_pkg::TICK_MID);
    assign bit_end = (tick_cnt == uart_pkg::TICK_LAST);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            o_busy <= 1'b0;
            o_valid <= 1'b0;
            o_data <= '0;
            wait_high <= 1'b0;
            tick_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '0;
        end
        else begin
            o_valid <= 1'b0;
            if (!o_busy) begin
                if (wait_high) begin
                    if (rx_sync == uart_pkg::LINE_IDLE) begin
                        wait_high <= 1'b0;
                    end
                end
                else if (start_edge) begin
                    o_busy <= 1'b1;
                    tick_cnt <= '0;
                    bit_cnt <= '0;
                end
            end
            else begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
                if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (sample) begin
                    if (bit_cnt == uart_pkg::BIT_START) begin
                        // start bit gone high again, treat as a glitch
                        if (rx_sync == uart_pkg::LINE_IDLE) begin
                            o_busy <= 1'b0;
                        end
                    end
                    else if (bit_cnt == uart_pkg::BIT_LAST) begin
                        o_busy <= 1'b0;
                        if (rx_sync == uart_pkg::LINE_IDLE) begin
                            o_data <= shift_q;
                            o_valid <= 1'b1;
                        end
                        else begin
                            wait_high <= 1'b1;
                        end
                    end
                    else begin
                        // data arrives lsb first
                        shift_q <= {rx_sync, shift_q[7:1]};
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
module uart_tx (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       i_start,
    input  logic [7:0] i_byte,
    output logic       o_busy,
    output logic       o_tx
);

    // cycle position inside the current bit
    logic [uart_pkg::TICK_WIDTH-1:0] tick_cnt;

    // which frame bit is on the line
    logic [uart_pkg::BIT_CNT_WIDTH-1:0] bit_cnt;

    // frame shifter, bit 0 drives the line
    logic [uart_pkg::FRAME_BITS-1:0] shift_q;

    logic bit_end;
    logic frame_end;

    assign bit_end = (tick_cnt == uart_pkg::TICK_LAST);
    assign frame_end = bit_end && (bit_cnt == uart_pkg::BIT_LAST);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            o_busy <= 1'b0;
            tick_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= {uart_pkg::FRAME_BITS{uart_pkg::LINE_IDLE}};
        end
        else if (!o_busy) begin
            // a start strobe while busy never reaches this branch
            if (i_start) begin
                o_busy <= 1'b1;
                tick_cnt <= '0;
                bit_cnt <= '0;
                shift_q <= {uart_pkg::LINE_IDLE, i_byte, ~uart_pkg::LINE_IDLE};
            end
        end
        else if (bit_end) begin
            tick_cnt <= '0;
            // shift in idle level so the line rests high after stop
            shift_q <= {uart_pkg::LINE_IDLE, shift_q[uart_pkg::FRAME_BITS-1:1]};
            if (frame_end) begin
                o_busy <= 1'b0;
                bit_cnt <= '0;
            end
            else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
        else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // start bit appears the cycle after the strobe, lsb first after it
    assign o_tx = shift_q[0];

endmodule

// ==== hdl/debug_pkg.sv ====
package debug_pkg;

    // status word and its byte count
    localparam int WORD_WIDTH = 32;
    localparam int WORD_BYTES = 4;
    localparam int IDX_WIDTH = $clog2(WORD_BYTES + 1);
    localparam logic [IDX_WIDTH-1:0] IDX_FIRST = IDX_WIDTH'(WORD_BYTES);

    // five frames of 160 cycles fit well inside one interval
    localparam int DUMP_INTERVAL = 1200;
    localparam int CNT_WIDTH = $clog2(DUMP_INTERVAL + 1);
    localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(DUMP_INTERVAL);

    localparam logic [7:0] TERMINATOR = 8'h0A;

    // sequencer states
    localparam int SEQ_WIDTH = 2;
    localparam logic [SEQ_WIDTH-1:0] SEQ_IDLE = 2'd0;
    localparam logic [SEQ_WIDTH-1:0] SEQ_LOAD = 2'd1;
    localparam logic [SEQ_WIDTH-1:0] SEQ_SEND = 2'd2;
    localparam logic [SEQ_WIDTH-1:0] SEQ_WAIT = 2'd3;

endpackage

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

    // serial bit timing, simulation scale
    localparam int TICKS_PER_BIT = 16;
    localparam int HALF_BIT = TICKS_PER_BIT / 2;
    localparam int TICK_WIDTH = $clog2(TICKS_PER_BIT);

    // last tick of a bit and the mid-bit sample tick
    localparam logic [TICK_WIDTH-1:0] TICK_LAST = TICK_WIDTH'(TICKS_PER_BIT - 1);
    localparam logic [TICK_WIDTH-1:0] TICK_MID = TICK_WIDTH'(HALF_BIT - 1);

    // 8N1 frame: start, eight data bits, stop
    localparam int FRAME_BITS = 10;
    localparam int BIT_CNT_WIDTH = $clog2(FRAME_BITS);
    localparam logic [BIT_CNT_WIDTH-1:0] BIT_START = '0;
    localparam logic [BIT_CNT_WIDTH-1:0] BIT_LAST = BIT_CNT_WIDTH'(FRAME_BITS - 1);

    // idle and stop level
    localparam logic LINE_IDLE = 1'b1;

endpackage
